// ==== Bender.yml ====
package:
  name: exu

sources:
  - rv_pkg.sv
  - exu_pkg.sv
  - exu_issue.sv
  - exu_alu.sv
  - exu_csr.sv
  - exu_redirect.sv
  - exu_result.sv
  - exu_top.sv
  - target: test
    files:
      - tb_exu.sv

// ==== exu_alu.sv ====
module exu_alu (
  input  rv_pkg::word_t   src1_i,
  input  rv_pkg::word_t   src2_i,
  input  rv_pkg::alu_op_t alu_op_i,
  output rv_pkg::word_t   res_o
);

  logic [4:0] shamt;
  logic       lt_s;
  logic       lt_u;
  logic       eq;

  assign shamt = src2_i[4:0];
  assign lt_s  = $signed(src1_i) < $signed(src2_i);
  assign lt_u  = src1_i < src2_i;
  assign eq    = (src1_i == src2_i);

  always_comb begin
    case (alu_op_i)
      rv_pkg::ALU_OP_ADD:  res_o = src1_i + src2_i;
      rv_pkg::ALU_OP_SUB:  res_o = src1_i - src2_i;
      rv_pkg::ALU_OP_AND:  res_o = src1_i & src2_i;
      rv_pkg::ALU_OP_OR:   res_o = src1_i | src2_i;
      rv_pkg::ALU_OP_XOR:  res_o = src1_i ^ src2_i;
      rv_pkg::ALU_OP_SLL:  res_o = src1_i << shamt;
      rv_pkg::ALU_OP_SRL:  res_o = src1_i >> shamt;
      rv_pkg::ALU_OP_SRA:  res_o = $signed(src1_i) >>> shamt;
      rv_pkg::ALU_OP_SLT:  res_o = {31'd0, lt_s};
      rv_pkg::ALU_OP_SLTU: res_o = {31'd0, lt_u};
      rv_pkg::ALU_OP_SLE:  res_o = {31'd0, lt_s | eq};   // Branch GE uses the inverse
      rv_pkg::ALU_OP_SLEU: res_o = {31'd0, lt_u | eq};
      default:             res_o = '0;
    endcase
  end

endmodule

// ==== exu_csr.sv ====
module exu_csr (
  input  logic              clk,
  input  logic              rst,
  input  rv_pkg::csr_addr_t addr_i,
  input  rv_pkg::word_t     wdata_i,
  input  bit                wen_i,
  input  bit                ecall_i,
  input  bit                mret_i,
  input  bit                commit_i,
  input  rv_pkg::word_t     pc_i,
  output rv_pkg::word_t     rdata_o,
  output rv_pkg::word_t     mepc_o,
  output rv_pkg::word_t     mtvec_o
);

  rv_pkg::word_t mstatus_q;
  rv_pkg::word_t mtvec_q;
  rv_pkg::word_t mepc_q;
  rv_pkg::word_t mcause_q;

  assign mepc_o  = mepc_q;
  assign mtvec_o = mtvec_q;

  always_comb begin
    case (addr_i)
      rv_pkg::CSR_MSTATUS: rdata_o = mstatus_q;
      rv_pkg::CSR_MTVEC:   rdata_o = mtvec_q;
      rv_pkg::CSR_MEPC:    rdata_o = mepc_q;
      rv_pkg::CSR_MCAUSE:  rdata_o = mcause_q;
      default:             rdata_o = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus_q <= '0;
      mtvec_q   <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else if (commit_i) begin
      if (ecall_i) begin
        mepc_q   <= pc_i;
        mcause_q <= rv_pkg::CAUSE_ECALL_M;
        // Trap entry stacks MIE and records M-mode as previous privilege
        mstatus_q[rv_pkg::MSTATUS_MPIE]                    <= mstatus_q[rv_pkg::MSTATUS_MIE];
        mstatus_q[rv_pkg::MSTATUS_MIE]                     <= 1'b0;
        mstatus_q[rv_pkg::MSTATUS_MPP+1:rv_pkg::MSTATUS_MPP] <= 2'b11;
      end else if (mret_i) begin
        mstatus_q[rv_pkg::MSTATUS_MIE]  <= mstatus_q[rv_pkg::MSTATUS_MPIE];
        mstatus_q[rv_pkg::MSTATUS_MPIE] <= 1'b1;
      end else if (wen_i) begin
        case (addr_i)
          rv_pkg::CSR_MSTATUS: mstatus_q <= wdata_i;
          rv_pkg::CSR_MTVEC:   mtvec_q   <= wdata_i;
          rv_pkg::CSR_MEPC:    mepc_q    <= wdata_i;
          rv_pkg::CSR_MCAUSE:  mcause_q  <= wdata_i;
          default: ;   // Unsupported address
        endcase
      end
    end
  end

  a_trap_excl: assert property (@(posedge clk) disable iff (rst)
    commit_i |-> !(ecall_i && mret_i));

endmodule

// ==== exu_issue.sv ====
module exu_issue (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::word_t    pc_i,
  input  rv_pkg::inst_t    inst_i,
  input  rv_pkg::word_t    imm_i,
  input  rv_pkg::word_t    op1_i,
  input  rv_pkg::word_t    op2_i,
  input  rv_pkg::word_t    opj_i,
  input  rv_pkg::alu_op_t  alu_op_i,
  input  rv_pkg::reg_idx_t rd_i,
  input  bit               ren_i,
  input  bit               wen_i,
  input  bit               jen_i,
  input  bit               ben_i,
  input  bit               system_i,
  input  bit               csr_wen_i,
  input  bit               ebreak_i,
  input  bit               ecall_i,
  input  bit               mret_i,
  input  bit               prev_valid_i,
  input  bit               next_ready_i,
  input  bit               lsu_rvalid_i,
  input  bit               lsu_wready_i,
  output rv_pkg::word_t    pc_o,
  output rv_pkg::inst_t    inst_o,
  output rv_pkg::word_t    imm_o,
  output rv_pkg::word_t    src1_o,
  output rv_pkg::word_t    src2_o,
  output rv_pkg::word_t    opj_o,
  output rv_pkg::word_t    addr_o,
  output rv_pkg::alu_op_t  alu_op_o,
  output rv_pkg::reg_idx_t rd_o,
  output logic             ren_o,
  output logic             wen_o,
  output logic             jen_o,
  output logic             ben_o,
  output logic             system_o,
  output logic             csr_wen_o,
  output logic             ebreak_o,
  output logic             ecall_o,
  output logic             mret_o,
  output logic             lsu_avalid_o,
  output logic             valid_o,
  output logic             ready_o,
  output logic             handoff_o
);

  exu_pkg::mem_state_t state_q;
  logic accept;
  logic lsu_rsp;

  assign ready_o      = (state_q != exu_pkg::MEM_REQ) & next_ready_i;
  assign accept       = prev_valid_i & ready_o;
  assign handoff_o    = valid_o & next_ready_i;
  assign lsu_avalid_o = (state_q == exu_pkg::MEM_REQ);
  assign lsu_rsp      = (ren_o & lsu_rvalid_i) | (wen_o & lsu_wready_i);
  assign addr_o       = opj_o + imm_o;   // Load/store and jump target

  // Instruction payload
  always_ff @(posedge clk) begin
    if (accept) begin
      pc_o     <= pc_i;
      inst_o   <= inst_i;
      imm_o    <= imm_i;
      src1_o   <= op1_i;
      src2_o   <= op2_i;
      opj_o    <= opj_i;
      alu_op_o <= alu_op_i;
      rd_o     <= rd_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ren_o     <= 1'b0;
      wen_o     <= 1'b0;
      jen_o     <= 1'b0;
      ben_o     <= 1'b0;
      system_o  <= 1'b0;
      csr_wen_o <= 1'b0;
      ebreak_o  <= 1'b0;
      ecall_o   <= 1'b0;
      mret_o    <= 1'b0;
    end else if (accept) begin
      ren_o     <= ren_i;
      wen_o     <= wen_i;
      jen_o     <= jen_i;
      ben_o     <= ben_i;
      system_o  <= system_i;
      csr_wen_o <= csr_wen_i;
      ebreak_o  <= ebreak_i;
      ecall_o   <= ecall_i;
      mret_o    <= mret_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= exu_pkg::MEM_IDLE;
      valid_o <= 1'b0;
    end else if (accept) begin
      if (ren_i | wen_i) begin
        state_q <= exu_pkg::MEM_REQ;   // Result waits for the LSU
        valid_o <= 1'b0;
      end else begin
        state_q <= exu_pkg::MEM_IDLE;
        valid_o <= 1'b1;
      end
    end else if (state_q == exu_pkg::MEM_REQ) begin
      if (lsu_rsp) begin
        state_q <= exu_pkg::MEM_DONE;
        valid_o <= 1'b1;
      end
    end else if (next_ready_i) begin
      state_q <= exu_pkg::MEM_IDLE;   // Handed off, nothing new
      valid_o <= 1'b0;
    end
  end

  a_ren_wen_excl: assert property (@(posedge clk) disable iff (rst)
    !(ren_o && wen_o));

  // Request held until a response pulse, and ended by it
  a_avalid_hold: assert property (@(posedge clk) disable iff (rst)
    lsu_avalid_o |=> (lsu_avalid_o == !$past(lsu_rvalid_i || lsu_wready_i)));

  a_no_rsp_idle: assert property (@(posedge clk) disable iff (rst)
    state_q == exu_pkg::MEM_IDLE |-> !(lsu_rvalid_i || lsu_wready_i));

endmodule

// ==== exu_pkg.sv ====
package exu_pkg;

  // LSU access progress for the latched instruction
  typedef enum logic [1:0] {
    MEM_IDLE,   // No access outstanding
    MEM_REQ,    // Request out, waiting for rvalid/wready
    MEM_DONE    // Response seen, result presented
  } mem_state_t;

  typedef logic [2:0] funct3_t;   // inst[14:12]

endpackage

// ==== exu_redirect.sv ====
module exu_redirect (
  input  rv_pkg::word_t    alu_res_i,
  input  rv_pkg::word_t    addr_i,
  input  rv_pkg::word_t    mtvec_i,
  input  rv_pkg::word_t    mepc_i,
  input  rv_pkg::word_t    src1_i,
  input  rv_pkg::word_t    csr_rdata_i,
  input  exu_pkg::funct3_t funct3_i,
  input  rv_pkg::alu_op_t  alu_op_i,
  input  bit               ben_i,
  input  bit               jen_i,
  input  bit               ecall_i,
  input  bit               mret_i,
  input  bit               system_i,
  input  bit               ren_i,
  output bit               use_npc_o,
  output bit               retire_branch_o,
  output rv_pkg::word_t    npc_o,
  output rv_pkg::word_t    csr_wdata_o
);

  assign retire_branch_o = system_i | ben_i | ren_i;
  assign npc_o = ecall_i ? mtvec_i : (mret_i ? mepc_i : addr_i);

  always_comb begin
    if (ben_i) begin
      case (alu_op_i)
        rv_pkg::ALU_OP_SUB:  use_npc_o = ~|alu_res_i;   // BEQ, BNE via XOR
        rv_pkg::ALU_OP_XOR,
        rv_pkg::ALU_OP_SLT,
        rv_pkg::ALU_OP_SLTU,
        rv_pkg::ALU_OP_SLE,
        rv_pkg::ALU_OP_SLEU: use_npc_o = |alu_res_i;
        default:             use_npc_o = 1'b0;
      endcase
    end else begin
      use_npc_o = jen_i | ecall_i | mret_i;
    end
  end

  // src1 already holds zimm for the immediate forms
  always_comb begin
    case (funct3_i)
      rv_pkg::F3_CSRRW, rv_pkg::F3_CSRRWI: csr_wdata_o = src1_i;
      rv_pkg::F3_CSRRS, rv_pkg::F3_CSRRSI: csr_wdata_o = csr_rdata_i | src1_i;
      rv_pkg::F3_CSRRC, rv_pkg::F3_CSRRCI: csr_wdata_o = csr_rdata_i & ~src1_i;
      default:                             csr_wdata_o = '0;
    endcase
  end

endmodule

// ==== exu_result.sv ====
module exu_result (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::word_t    lsu_rdata_i,
  input  bit               lsu_rvalid_i,
  input  bit               ren_i,
  input  bit               system_i,
  input  rv_pkg::word_t    csr_rdata_i,
  input  rv_pkg::word_t    alu_res_i,
  input  rv_pkg::reg_idx_t rd_i,
  output rv_pkg::word_t    reg_wdata_o
);

  rv_pkg::word_t load_q;
  rv_pkg::word_t sel;

  // Load data arrives as a pulse, hold it while the result is presented
  always_ff @(posedge clk) begin
    if (rst) begin
      load_q <= '0;
    end else if (lsu_rvalid_i && ren_i) begin
      load_q <= lsu_rdata_i;
    end
  end

  always_comb begin
    if (ren_i) begin
      sel = load_q;
    end else if (system_i) begin
      sel = csr_rdata_i;   // Old CSR value
    end else begin
      sel = alu_res_i;
    end
  end

  assign reg_wdata_o = (rd_i == '0) ? '0 : sel;   // x0 stays zero

endmodule

// ==== exu_top.sv ====
module exu_top (
  input  logic             clk,
  input  logic             rst,
  input  rv_pkg::word_t    pc_i,
  input  rv_pkg::inst_t    inst_i,
  input  rv_pkg::word_t    imm_i,
  input  rv_pkg::word_t    op1_i,
  input  rv_pkg::word_t    op2_i,
  input  rv_pkg::word_t    opj_i,
  input  rv_pkg::alu_op_t  alu_op_i,
  input  rv_pkg::reg_idx_t rd_i,
  input  bit               ren_i,
  input  bit               wen_i,
  input  bit               jen_i,
  input  bit               ben_i,
  input  bit               system_i,
  input  bit               csr_wen_i,
  input  bit               ebreak_i,
  input  bit               ecall_i,
  input  bit               mret_i,
  input  bit               prev_valid_i,
  output logic             ready_o,
  output logic             lsu_avalid_o,
  output logic             ren_o,
  output logic             wen_o,
  output rv_pkg::word_t    rwaddr_o,
  output rv_pkg::word_t    lsu_wdata_o,
  output rv_pkg::alu_op_t  alu_op_o,
  input  rv_pkg::word_t    lsu_rdata_i,
  input  bit               lsu_rvalid_i,
  input  bit               lsu_wready_i,
  output logic             valid_o,
  output rv_pkg::inst_t    inst_o,
  output rv_pkg::word_t    pc_o,
  output rv_pkg::reg_idx_t rd_o,
  output rv_pkg::word_t    reg_wdata_o,
  output rv_pkg::word_t    npc_wdata_o,
  output bit               use_npc_o,
  output bit               retire_branch_o,
  output logic             ebreak_o,
  input  bit               next_ready_i
);

  rv_pkg::word_t imm;
  rv_pkg::word_t src1;
  rv_pkg::word_t alu_res;
  rv_pkg::word_t csr_rdata;
  rv_pkg::word_t csr_wdata;
  rv_pkg::word_t mepc;
  rv_pkg::word_t mtvec;
  logic jen;
  logic ben;
  logic system;
  logic csr_wen;
  logic ecall;
  logic mret;
  logic handoff;

  exu_issue i_issue (
    .clk          (clk),
    .rst          (rst),
    .pc_i         (pc_i),
    .inst_i       (inst_i),
    .imm_i        (imm_i),
    .op1_i        (op1_i),
    .op2_i        (op2_i),
    .opj_i        (opj_i),
    .alu_op_i     (alu_op_i),
    .rd_i         (rd_i),
    .ren_i        (ren_i),
    .wen_i        (wen_i),
    .jen_i        (jen_i),
    .ben_i        (ben_i),
    .system_i     (system_i),
    .csr_wen_i    (csr_wen_i),
    .ebreak_i     (ebreak_i),
    .ecall_i      (ecall_i),
    .mret_i       (mret_i),
    .prev_valid_i (prev_valid_i),
    .next_ready_i (next_ready_i),
    .lsu_rvalid_i (lsu_rvalid_i),
    .lsu_wready_i (lsu_wready_i),
    .pc_o         (pc_o),
    .inst_o       (inst_o),
    .imm_o        (imm),
    .src1_o       (src1),
    .src2_o       (lsu_wdata_o),   // Store data is op2
    .opj_o        (),
    .addr_o       (rwaddr_o),
    .alu_op_o     (alu_op_o),
    .rd_o         (rd_o),
    .ren_o        (ren_o),
    .wen_o        (wen_o),
    .jen_o        (jen),
    .ben_o        (ben),
    .system_o     (system),
    .csr_wen_o    (csr_wen),
    .ebreak_o     (ebreak_o),
    .ecall_o      (ecall),
    .mret_o       (mret),
    .lsu_avalid_o (lsu_avalid_o),
    .valid_o      (valid_o),
    .ready_o      (ready_o),
    .handoff_o    (handoff)
  );

  exu_alu i_alu (
    .src1_i   (src1),
    .src2_i   (lsu_wdata_o),
    .alu_op_i (alu_op_o),
    .res_o    (alu_res)
  );

  // CSR address sits in the I-type immediate
  exu_csr i_csr (
    .clk      (clk),
    .rst      (rst),
    .addr_i   (imm[11:0]),
    .wdata_i  (csr_wdata),
    .wen_i    (csr_wen),
    .ecall_i  (ecall),
    .mret_i   (mret),
    .commit_i (handoff),
    .pc_i     (pc_o),
    .rdata_o  (csr_rdata),
    .mepc_o   (mepc),
    .mtvec_o  (mtvec)
  );

  exu_redirect i_redirect (
    .alu_res_i       (alu_res),
    .addr_i          (rwaddr_o),
    .mtvec_i         (mtvec),
    .mepc_i          (mepc),
    .src1_i          (src1),
    .csr_rdata_i     (csr_rdata),
    .funct3_i        (inst_o[14:12]),
    .alu_op_i        (alu_op_o),
    .ben_i           (ben),
    .jen_i           (jen),
    .ecall_i         (ecall),
    .mret_i          (mret),
    .system_i        (system),
    .ren_i           (ren_o),
    .use_npc_o       (use_npc_o),
    .retire_branch_o (retire_branch_o),
    .npc_o           (npc_wdata_o),
    .csr_wdata_o     (csr_wdata)
  );

  exu_result i_result (
    .clk          (clk),
    .rst          (rst),
    .lsu_rdata_i  (lsu_rdata_i),
    .lsu_rvalid_i (lsu_rvalid_i),
    .ren_i        (ren_o),
    .system_i     (system),
    .csr_rdata_i  (csr_rdata),
    .alu_res_i    (alu_res),
    .rd_i         (rd_o),
    .reg_wdata_o  (reg_wdata_o)
  );

endmodule

// ==== flist.f ====
rv_pkg.sv
exu_pkg.sv
exu_issue.sv
exu_alu.sv
exu_csr.sv
exu_redirect.sv
exu_result.sv
exu_top.sv
tb_exu.sv

// ==== rv_pkg.sv ====
package rv_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] inst_t;
  typedef logic [3:0]  reg_idx_t;   // 16-entry register file
  typedef logic [3:0]  alu_op_t;
  typedef logic [11:0] csr_addr_t;

  // ALU operation codes, also the access size code seen by the LSU
  localparam alu_op_t ALU_OP_ADD  = 4'd0;
  localparam alu_op_t ALU_OP_SUB  = 4'd1;
  localparam alu_op_t ALU_OP_AND  = 4'd2;
  localparam alu_op_t ALU_OP_OR   = 4'd3;
  localparam alu_op_t ALU_OP_XOR  = 4'd4;
  localparam alu_op_t ALU_OP_SLL  = 4'd5;
  localparam alu_op_t ALU_OP_SRL  = 4'd6;
  localparam alu_op_t ALU_OP_SRA  = 4'd7;
  localparam alu_op_t ALU_OP_SLT  = 4'd8;
  localparam alu_op_t ALU_OP_SLTU = 4'd9;
  localparam alu_op_t ALU_OP_SLE  = 4'd10;
  localparam alu_op_t ALU_OP_SLEU = 4'd11;

  // Zicsr funct3
  localparam logic [2:0] F3_CSRRW  = 3'b001;
  localparam logic [2:0] F3_CSRRS  = 3'b010;
  localparam logic [2:0] F3_CSRRC  = 3'b011;
  localparam logic [2:0] F3_CSRRWI = 3'b101;
  localparam logic [2:0] F3_CSRRSI = 3'b110;
  localparam logic [2:0] F3_CSRRCI = 3'b111;

  // Machine-mode CSRs
  localparam csr_addr_t CSR_MSTATUS = 12'h300;
  localparam csr_addr_t CSR_MTVEC   = 12'h305;
  localparam csr_addr_t CSR_MEPC    = 12'h341;
  localparam csr_addr_t CSR_MCAUSE  = 12'h342;

  // mstatus fields touched by trap entry and return
  localparam int MSTATUS_MIE  = 3;
  localparam int MSTATUS_MPIE = 7;
  localparam int MSTATUS_MPP  = 11;   // Low bit of the two-bit MPP field

  localparam word_t CAUSE_ECALL_M = 32'd11;

endpackage

// ==== tb_exu.sv ====
module tb_exu;

  localparam int NUM_INSTR = 104;   // Instructions issued over all tests
  localparam int FL_REN    = 0;
  localparam int FL_WEN    = 1;
  localparam int FL_JEN    = 2;
  localparam int FL_BEN    = 3;
  localparam int FL_SYS    = 4;
  localparam int FL_CSRW   = 5;
  localparam int FL_ECALL  = 6;
  localparam int FL_MRET   = 7;
  localparam int FL_EBRK   = 8;

  logic clk = 1'b0;
  logic rst;
  rv_pkg::word_t    pc_i, imm_i, op1_i, op2_i, opj_i, lsu_rdata_i;
  rv_pkg::inst_t    inst_i;
  rv_pkg::alu_op_t  alu_op_i;
  rv_pkg::reg_idx_t rd_i;
  logic ren_i, wen_i, jen_i, ben_i, system_i, csr_wen_i, ebreak_i, ecall_i, mret_i;
  logic prev_valid_i, next_ready_i, lsu_rvalid_i, lsu_wready_i;
  logic ready_o, lsu_avalid_o, ren_o, wen_o, valid_o, use_npc_o, retire_branch_o, ebreak_o;
  rv_pkg::word_t    rwaddr_o, lsu_wdata_o, pc_o, reg_wdata_o, npc_wdata_o;
  rv_pkg::alu_op_t  alu_op_o;
  rv_pkg::inst_t    inst_o;
  rv_pkg::reg_idx_t rd_o;

  rv_pkg::word_t mem [64];
  rv_pkg::word_t csr_mstatus, csr_mtvec, csr_mepc, csr_mcause;   // CSR reference model
  rv_pkg::alu_op_t br_ops [6] = '{rv_pkg::ALU_OP_SUB, rv_pkg::ALU_OP_XOR, rv_pkg::ALU_OP_SLT,
                                  rv_pkg::ALU_OP_SLTU, rv_pkg::ALU_OP_SLE, rv_pkg::ALU_OP_SLEU};

  // Fields of the last issued instruction
  rv_pkg::word_t    exp_pc;
  rv_pkg::inst_t    exp_inst;
  rv_pkg::reg_idx_t exp_rd;
  rv_pkg::alu_op_t  exp_op;
  logic [8:0]       exp_flags;

  exu_top i_dut (.*);

  always #4 clk = ~clk;

  // LSU model with a random response delay
  initial begin
    int delay;
    forever begin
      @(posedge clk);
      if (lsu_avalid_o) begin
        delay = $urandom_range(0, 5);
        repeat (delay) @(posedge clk);
        if (ren_o) begin
          lsu_rdata_i  <= mem[rwaddr_o[7:2]];
          lsu_rvalid_i <= 1'b1;
        end else begin
          mem[rwaddr_o[7:2]] = lsu_wdata_o;
          lsu_wready_i <= 1'b1;
        end
        @(posedge clk);
        lsu_rvalid_i <= 1'b0;
        lsu_wready_i <= 1'b0;
      end
    end
  end

  initial begin
    repeat (NUM_INSTR * 20 + 10) @(posedge clk);
    $display("Timeout: the tests did not finish in the expected number of cycles");
    $display("tests failed");
    $fatal(1);
  end

  task automatic compare_word(input string name, input rv_pkg::word_t act,
                              input rv_pkg::word_t exp);
    assert (act === exp) else begin
      $display("[ERROR] %s: expected %h, got %h", name, exp, act);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  task automatic require(input bit cond, input string what);
    assert (cond) else begin
      $display("%s", what);
      $display("tests failed");
      $fatal(1);
    end
  endtask

  function automatic rv_pkg::word_t alu_model(input rv_pkg::alu_op_t op,
                                              input rv_pkg::word_t a, input rv_pkg::word_t b);
    case (op)
      rv_pkg::ALU_OP_ADD:  return a + b;
      rv_pkg::ALU_OP_SUB:  return a - b;
      rv_pkg::ALU_OP_AND:  return a & b;
      rv_pkg::ALU_OP_OR:   return a | b;
      rv_pkg::ALU_OP_XOR:  return a ^ b;
      rv_pkg::ALU_OP_SLL:  return a << b[4:0];
      rv_pkg::ALU_OP_SRL:  return a >> b[4:0];
      rv_pkg::ALU_OP_SRA:  return $signed(a) >>> b[4:0];
      rv_pkg::ALU_OP_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      rv_pkg::ALU_OP_SLTU: return (a < b) ? 32'd1 : 32'd0;
      rv_pkg::ALU_OP_SLE:  return ($signed(a) <= $signed(b)) ? 32'd1 : 32'd0;
      rv_pkg::ALU_OP_SLEU: return (a <= b) ? 32'd1 : 32'd0;
      default:             return 32'd0;
    endcase
  endfunction

  function automatic rv_pkg::word_t modeled_csr(input rv_pkg::csr_addr_t addr);
    case (addr)
      rv_pkg::CSR_MSTATUS: return csr_mstatus;
      rv_pkg::CSR_MTVEC:   return csr_mtvec;
      rv_pkg::CSR_MEPC:    return csr_mepc;
      rv_pkg::CSR_MCAUSE:  return csr_mcause;
      default:             return 32'd0;
    endcase
  endfunction

  // Present one instruction and wait for acceptance
  task automatic issue(input rv_pkg::word_t pc, input rv_pkg::inst_t inst,
                       input rv_pkg::word_t imm, input rv_pkg::word_t op1,
                       input rv_pkg::word_t op2, input rv_pkg::word_t opj,
                       input rv_pkg::alu_op_t op, input rv_pkg::reg_idx_t rd,
                       input logic [8:0] flags, input bit hold);
    int waited;
    bit accepted;
    bit was_valid;
    waited = 0;
    exp_pc = pc;
    exp_inst = inst;
    exp_rd = rd;
    exp_op = op;
    exp_flags = flags;
    @(posedge clk);
    pc_i <= pc;
    inst_i <= inst;
    imm_i <= imm;
    op1_i <= op1;
    op2_i <= op2;
    opj_i <= opj;
    alu_op_i <= op;
    rd_i <= rd;
    ren_i <= flags[FL_REN];
    wen_i <= flags[FL_WEN];
    jen_i <= flags[FL_JEN];
    ben_i <= flags[FL_BEN];
    system_i <= flags[FL_SYS];
    csr_wen_i <= flags[FL_CSRW];
    ecall_i <= flags[FL_ECALL];
    mret_i <= flags[FL_MRET];
    ebreak_i <= flags[FL_EBRK];
    prev_valid_i <= 1'b1;
    do begin
      @(posedge clk);
      waited++;
      accepted = prev_valid_i && ready_o;
      was_valid = valid_o;
    end while (!accepted && waited < 20);
    require(accepted, "Instruction was not accepted within 20 cycles");
    require(!was_valid, "valid_o was still high when the next instruction was accepted");
    prev_valid_i <= 1'b0;
    if (hold) next_ready_i <= 1'b0;
  endtask

  // Presented fields follow the issued instruction
  task automatic verify_latched();
    compare_word("pc_o", pc_o, exp_pc);
    compare_word("inst_o", inst_o, exp_inst);
    compare_word("rd_o", rd_o, exp_rd);
    compare_word("alu_op_o", alu_op_o, exp_op);
    compare_word("ren_o", ren_o, exp_flags[FL_REN]);
    compare_word("wen_o", wen_o, exp_flags[FL_WEN]);
    compare_word("ebreak_o", ebreak_o, exp_flags[FL_EBRK]);
    compare_word("lsu_avalid_o", lsu_avalid_o, 0);
  endtask

  // Sample at falling edges until valid_o, with LSU checks on the way
  task automatic wait_result(input bit is_mem, input rv_pkg::word_t exp_addr,
                             input rv_pkg::word_t exp_wdata, output int lat);
    bit pulse_prev;
    pulse_prev = 1'b0;
    lat = 0;
    do begin
      @(negedge clk);
      lat++;
      if (lat == 1)
        compare_word("lsu_avalid_o", lsu_avalid_o, is_mem);
      if (lsu_avalid_o) begin
        require(!ready_o, "ready_o was high while the LSU request was pending");
        compare_word("rwaddr_o", rwaddr_o, exp_addr);
        compare_word("lsu_wdata_o", lsu_wdata_o, exp_wdata);
      end
      if (valid_o && is_mem)
        require(pulse_prev, "valid_o did not rise the cycle after the LSU response");
      pulse_prev = lsu_rvalid_i | lsu_wready_i;
    end while (!valid_o && lat < 40);
    require(valid_o, "valid_o did not rise within 40 cycles");
    verify_latched();
  endtask

  task automatic access_csr(input logic [2:0] f3, input rv_pkg::csr_addr_t addr,
                            input rv_pkg::word_t src, input bit wr);
    rv_pkg::word_t old;
    rv_pkg::word_t nxt;
    int lat;
    old = modeled_csr(addr);
    issue(32'h100, {addr, 5'd1, f3, 5'd5, 7'h73}, {20'd0, addr}, src, 32'd0, 32'd0,
          rv_pkg::ALU_OP_ADD, 4'd5, 8'(1 << FL_SYS) | (wr ? 8'(1 << FL_CSRW) : 8'd0), 1'b0);
    wait_result(1'b0, 32'd0, 32'd0, lat);
    compare_word("reg_wdata_o", reg_wdata_o, old);
    case (f3)
      rv_pkg::F3_CSRRW, rv_pkg::F3_CSRRWI: nxt = src;
      rv_pkg::F3_CSRRS, rv_pkg::F3_CSRRSI: nxt = old | src;
      default:                             nxt = old & ~src;
    endcase
    if (wr) begin
      case (addr)
        rv_pkg::CSR_MSTATUS: csr_mstatus = nxt;
        rv_pkg::CSR_MTVEC:   csr_mtvec = nxt;
        rv_pkg::CSR_MEPC:    csr_mepc = nxt;
        rv_pkg::CSR_MCAUSE:  csr_mcause = nxt;
        default: ;
      endcase
    end
  endtask

  task automatic arith_ops();
    rv_pkg::word_t a, b;
    rv_pkg::reg_idx_t rd;
    int lat;
    for (int op = 0; op < 12; op++) begin
      repeat (4) begin
        a = $urandom;
        b = ($urandom_range(0, 3) == 0) ? a : $urandom;
        rd = $urandom_range(1, 15);
        issue(32'h200, 32'h33, $urandom, a, b, 32'd0, op, rd, 8'd0, 1'b0);
        wait_result(1'b0, 32'd0, 32'd0, lat);
        require(lat == 1, "valid_o did not rise one cycle after acceptance");
        compare_word("reg_wdata_o", reg_wdata_o, alu_model(op, a, b));
        compare_word("use_npc_o", use_npc_o, 0);
      end
    end
  endtask

  task automatic branches_jumps();
    rv_pkg::word_t a, b, opj, imm, res;
    int lat;
    for (int i = 0; i < 6; i++) begin
      for (int eq = 0; eq < 2; eq++) begin
        a = $urandom;
        b = eq ? a : $urandom;
        opj = $urandom & ~32'h3;
        imm = $urandom_range(0, 255) * 4;
        res = alu_model(br_ops[i], a, b);
        issue(32'h300, 32'h63, imm, a, b, opj, br_ops[i], 4'd0, 8'(1 << FL_BEN), 1'b0);
        wait_result(1'b0, 32'd0, 32'd0, lat);
        compare_word("use_npc_o", use_npc_o,
                     (br_ops[i] == rv_pkg::ALU_OP_SUB) ? (res == 0) : (res != 0));
        compare_word("npc_wdata_o", npc_wdata_o, opj + imm);
        compare_word("retire_branch_o", retire_branch_o, 1);
      end
    end
    repeat (2) begin
      opj = $urandom & ~32'h3;
      imm = $urandom_range(0, 255) * 4;
      issue(32'h400, 32'h6f, imm, 32'h400, 32'd4, opj, rv_pkg::ALU_OP_ADD, 4'd1,
            8'(1 << FL_JEN), 1'b0);
      wait_result(1'b0, 32'd0, 32'd0, lat);
      compare_word("use_npc_o", use_npc_o, 1);
      compare_word("npc_wdata_o", npc_wdata_o, opj + imm);
      compare_word("retire_branch_o", retire_branch_o, 0);
    end
  endtask

  task automatic store_load();
    rv_pkg::word_t addr [4];
    rv_pkg::word_t data [4];
    rv_pkg::word_t imm;
    int lat;
    for (int i = 0; i < 4; i++) begin
      imm = $urandom_range(0, 3) * 4;
      addr[i] = i * 16 + imm;
      data[i] = $urandom;
      issue(32'h500, 32'h23, imm, 32'd0, data[i], i * 16, rv_pkg::ALU_OP_ADD, 4'd0,
            8'(1 << FL_WEN), 1'b0);
      wait_result(1'b1, addr[i], data[i], lat);
    end
    for (int i = 3; i >= 0; i--) begin
      issue(32'h600, 32'h03, addr[i], 32'd0, 32'd0, 32'd0, rv_pkg::ALU_OP_ADD, 4'd7,
            8'(1 << FL_REN), 1'b0);
      wait_result(1'b1, addr[i], 32'd0, lat);
      compare_word("reg_wdata_o", reg_wdata_o, data[i]);
    end
  endtask

  task automatic zicsr_ops();
    rv_pkg::csr_addr_t addrs [3] = '{rv_pkg::CSR_MTVEC, rv_pkg::CSR_MSTATUS, rv_pkg::CSR_MCAUSE};
    foreach (addrs[i]) begin
      access_csr(rv_pkg::F3_CSRRW, addrs[i], $urandom, 1'b1);
      access_csr(rv_pkg::F3_CSRRS, addrs[i], 32'd0, 1'b0);
      access_csr(rv_pkg::F3_CSRRS, addrs[i], $urandom, 1'b1);
      access_csr(rv_pkg::F3_CSRRS, addrs[i], 32'd0, 1'b0);
      access_csr(rv_pkg::F3_CSRRC, addrs[i], $urandom, 1'b1);
      access_csr(rv_pkg::F3_CSRRS, addrs[i], 32'd0, 1'b0);
    end
    access_csr(rv_pkg::F3_CSRRSI, rv_pkg::CSR_MTVEC, 32'd21, 1'b1);
    access_csr(rv_pkg::F3_CSRRS, rv_pkg::CSR_MTVEC, 32'd0, 1'b0);
    access_csr(rv_pkg::F3_CSRRCI, rv_pkg::CSR_MTVEC, 32'd7, 1'b1);
    access_csr(rv_pkg::F3_CSRRS, rv_pkg::CSR_MTVEC, 32'd0, 1'b0);
    access_csr(rv_pkg::F3_CSRRW, 12'h7c0, $urandom, 1'b1);   // Unsupported, reads zero
    access_csr(rv_pkg::F3_CSRRS, 12'h7c0, 32'd0, 1'b0);
  endtask

  task automatic trap_flow();
    rv_pkg::word_t pc;
    int lat;
    access_csr(rv_pkg::F3_CSRRW, rv_pkg::CSR_MTVEC, 32'h0000_1f00, 1'b1);
    pc = $urandom & ~32'h3;
    issue(pc, 32'h73, 32'd0, 32'd0, 32'd0, 32'd0, rv_pkg::ALU_OP_ADD, 4'd0,
          8'(1 << FL_SYS) | 8'(1 << FL_ECALL), 1'b0);
    wait_result(1'b0, 32'd0, 32'd0, lat);
    compare_word("use_npc_o", use_npc_o, 1);
    compare_word("npc_wdata_o", npc_wdata_o, csr_mtvec);
    csr_mepc = pc;
    csr_mcause = rv_pkg::CAUSE_ECALL_M;
    access_csr(rv_pkg::F3_CSRRS, rv_pkg::CSR_MEPC, 32'd0, 1'b0);
    access_csr(rv_pkg::F3_CSRRS, rv_pkg::CSR_MCAUSE, 32'd0, 1'b0);
    issue(32'h700, 32'h3020_0073, 32'd0, 32'd0, 32'd0, 32'd0, rv_pkg::ALU_OP_ADD, 4'd0,
          8'(1 << FL_SYS) | 8'(1 << FL_MRET), 1'b0);
    wait_result(1'b0, 32'd0, 32'd0, lat);
    compare_word("use_npc_o", use_npc_o, 1);
    compare_word("npc_wdata_o", npc_wdata_o, pc);
    // ebreak is only flagged to write-back
    issue(32'h710, 32'h0010_0073, 32'd0, 32'd0, 32'd0, 32'd0, rv_pkg::ALU_OP_ADD, 4'd0,
          9'(1 << FL_SYS) | 9'(1 << FL_EBRK), 1'b0);
    wait_result(1'b0, 32'd0, 32'd0, lat);
    compare_word("use_npc_o", use_npc_o, 0);
    compare_word("retire_branch_o", retire_branch_o, 1);
  endtask

  task automatic stall_hold();
    rv_pkg::word_t pc, imm, op1, op2, opj;
    int lat;
    repeat (3) begin
      pc = $urandom;
      imm = $urandom;
      op1 = $urandom;
      op2 = $urandom;
      opj = $urandom;
      issue(pc, 32'h33, imm, op1, op2, opj, rv_pkg::ALU_OP_XOR, 4'd9, 8'd0, 1'b1);
      wait_result(1'b0, 32'd0, 32'd0, lat);
      repeat ($urandom_range(1, 6)) begin
        @(negedge clk);
        require(!ready_o, "ready_o was high while next_ready_i was low");
        require(valid_o, "valid_o dropped while next_ready_i was low");
        compare_word("reg_wdata_o", reg_wdata_o, op1 ^ op2);
        compare_word("npc_wdata_o", npc_wdata_o, opj + imm);
        compare_word("use_npc_o", use_npc_o, 0);
        compare_word("retire_branch_o", retire_branch_o, 0);
        verify_latched();
      end
      @(posedge clk);
      next_ready_i <= 1'b1;
    end
    issue(32'h800, 32'h33, 32'd0, 32'h1234, 32'h5678, 32'd0, rv_pkg::ALU_OP_ADD, 4'd0,
          8'd0, 1'b0);
    wait_result(1'b0, 32'd0, 32'd0, lat);
    compare_word("reg_wdata_o", reg_wdata_o, 32'd0);
  endtask

  initial begin
    void'($urandom(32'h969e_cebd));
    for (int i = 0; i < 64; i++) mem[i] = 32'h5a00_0000 ^ (i * 32'h0103_0507);
    csr_mstatus = '0;
    csr_mtvec = '0;
    csr_mepc = '0;
    csr_mcause = '0;
    rst = 1'b1;
    {pc_i, imm_i, op1_i, op2_i, opj_i, lsu_rdata_i, inst_i} = '0;
    alu_op_i = '0;
    rd_i = '0;
    {ren_i, wen_i, jen_i, ben_i, system_i, csr_wen_i, ebreak_i, ecall_i, mret_i} = '0;
    prev_valid_i = 1'b0;
    next_ready_i = 1'b1;
    lsu_rvalid_i = 1'b0;
    lsu_wready_i = 1'b0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    require(!valid_o && !lsu_avalid_o && !ren_o && !wen_o && !use_npc_o && ready_o,
            "Outputs were not idle after reset");
    arith_ops();
    branches_jumps();
    store_load();
    zicsr_ops();
    trap_flow();
    stall_hold();
    $display("all tests passed");
    $finish;
  end

endmodule
